//--- files.f
hdl/vic_pkg.sv
hdl/dot_timing.sv
hdl/vic_regs.sv
hdl/pixel_sequencer.sv
hdl/vic_video_top.sv
verif/pixel_checker.sv
verif/tb_vic_video.sv

//--- hdl/dot_timing.sv
`timescale 1ns/10ps
`default_nettype none

module dot_timing
    import vic_pkg::*;
#(
    parameter int cycles_per_line = CYCLES_PER_LINE
) (
    input  wire        clk_dot4x,
    input  wire        rst_n_i,
    output logic [3:0] dot_rising_o,
    output logic [2:0] cycle_bit_o,
    output logic [6:0] cycle_num_o,
    output logic       phi_dav_o
);

    localparam logic [6:0] LAST_CYCLE = 7'(cycles_per_line - 1);

    logic dot_end;
    logic cycle_end;

    // Last quarter of a dot, and last quarter of dot 7
    assign dot_end   = dot_rising_o[3];
    assign cycle_end = dot_end && (cycle_bit_o == 3'd7);

    always_ff @(posedge clk_dot4x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dot_rising_o <= 4'b0001;
            cycle_bit_o  <= 3'd0;
            cycle_num_o  <= 7'd0;
            phi_dav_o    <= 1'b0;
        end else begin
            dot_rising_o <= {dot_rising_o[2:0], dot_rising_o[3]};

            // High for the first quarter of dot 0
            phi_dav_o <= cycle_end;

            if (dot_end) begin
                cycle_bit_o <= cycle_bit_o + 3'd1;
            end

            if (cycle_end) begin
                if (cycle_num_o == LAST_CYCLE) begin
                    cycle_num_o <= 7'd0;
                end else begin
                    cycle_num_o <= cycle_num_o + 7'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixel_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_sequencer
    import vic_pkg::*;
(
    input  wire         clk_dot4x,
    input  wire         rst_n_i,
    input  wire  [3:0]  dot_rising_i,
    input  wire  [2:0]  cycle_bit_i,
    input  wire  [6:0]  cycle_num_i,
    input  wire         phi_dav_i,
    input  wire  [11:0] char_i,
    input  wire  [7:0]  pixels_i,
    input  wire  [3:0]  b0c_i,
    input  wire  [3:0]  b1c_i,
    input  wire  [3:0]  b2c_i,
    input  wire  [3:0]  b3c_i,
    input  wire  [3:0]  ec_i,
    input  wire         ecm_i,
    input  wire         bmm_i,
    input  wire         mcm_i,
    input  wire  [2:0]  xscroll_i,
    output logic [3:0]  pixel_color_o,
    output logic        pixel_valid_o
);

    logic        visible;
    logic        load;
    logic [11:0] char_d0;
    logic [11:0] char_d1;
    logic [11:0] char_d2;
    logic [7:0]  pixels_d0;
    logic [7:0]  pixels_d1;
    logic [7:0]  pixels_d2;
    logic [2:0]  xscroll_d0;
    logic [2:0]  xscroll_d;
    logic [11:0] char_shift;
    logic [7:0]  pixel_shift;
    logic [11:0] char_cur;
    logic [7:0]  pixels_cur;
    logic        mc_ff;
    logic        mc_cur;
    logic        mcm_d;
    logic        bmm_d;
    logic        ecm_d;
    logic        mcm_prev;
    logic        mcm_n;
    logic        bmm_n;
    logic        ecm_n;
    logic        mcm_prev_n;
    logic        cell_mc;
    mode_e       pv_mode;
    logic [1:0]  pv_bits;
    logic        border_s0;
    logic [3:0]  b0c_s;
    logic [3:0]  b1c_s;
    logic [3:0]  b2c_s;
    logic [3:0]  b3c_s;
    logic [3:0]  ec_s;
    logic        stage0;
    logic        stage1;
    logic [3:0]  color_dec;
    logic [3:0]  color_s1;

    assign visible = (cycle_num_i >= VIS_FIRST) && (cycle_num_i <= VIS_LAST);

    // Shifter load point, evaluated on dot start
    assign load = (cycle_bit_i == xscroll_d);

    // Fetched data of cycle c reaches char_d2 at the start of cycle c+2
    always_ff @(posedge clk_dot4x) begin
        if (phi_dav_i) begin
            char_d0   <= char_i;
            char_d1   <= char_d0;
            char_d2   <= char_d1;
            pixels_d0 <= pixels_i;
            pixels_d1 <= pixels_d0;
            pixels_d2 <= pixels_d1;
        end
    end

    always_ff @(posedge clk_dot4x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xscroll_d0 <= 3'd0;
            xscroll_d  <= 3'd0;
        end else if (phi_dav_i) begin
            xscroll_d0 <= xscroll_i;
            // Scroll only moves inside the display window
            if (visible) begin
                xscroll_d <= xscroll_d0;
            end
        end
    end

    // Mode bits settle over dots 4, 6 and 7; values below apply to the current dot
    always_comb begin
        mcm_n      = mcm_d;
        bmm_n      = bmm_d;
        ecm_n      = ecm_d;
        mcm_prev_n = mcm_prev;
        mc_cur     = mc_ff;
        case (cycle_bit_i)
            3'd4: begin
                mcm_n = mcm_i;
                bmm_n = bmm_d | bmm_i;
                ecm_n = ecm_d | ecm_i;
            end
            3'd6: begin
                bmm_n = bmm_d & bmm_i;
                ecm_n = ecm_d & ecm_i;
            end
            3'd7: begin
                // Rising MCM restarts the pair phase
                if (mcm_d && !mcm_prev) begin
                    mc_cur = 1'b0;
                end
                mcm_prev_n = mcm_d;
            end
            default: begin
                mcm_n = mcm_d;
            end
        endcase

        if (load) begin
            mc_cur = 1'b1;
            if (visible) begin
                char_cur   = char_d2;
                pixels_cur = pixels_d2;
            end else begin
                char_cur   = 12'd0;
                pixels_cur = 8'd0;
            end
        end else begin
            char_cur   = char_shift;
            pixels_cur = pixel_shift;
        end

        cell_mc = bmm_n | char_cur[11];
    end

    always_ff @(posedge clk_dot4x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mcm_d         <= 1'b0;
            bmm_d         <= 1'b0;
            ecm_d         <= 1'b0;
            mcm_prev      <= 1'b0;
            mc_ff         <= 1'b0;
            stage0        <= 1'b0;
            stage1        <= 1'b0;
            pixel_valid_o <= 1'b0;
        end else begin
            stage0        <= dot_rising_i[1];
            stage1        <= stage0;
            pixel_valid_o <= stage1;
            if (dot_rising_i[1]) begin
                mcm_d    <= mcm_n;
                bmm_d    <= bmm_n;
                ecm_d    <= ecm_n;
                mcm_prev <= mcm_prev_n;
                mc_ff    <= mc_cur;
            end else if (dot_rising_i[3]) begin
                // Half-rate toggle for multicolour pairs
                mc_ff <= ~mc_ff;
            end
        end
    end

    // Dot start: shift and form the pixel value
    always_ff @(posedge clk_dot4x) begin
        if (dot_rising_i[1]) begin
            char_shift  <= char_cur;
            pixel_shift <= {pixels_cur[6:0], 1'b0};
            pv_mode     <= mode_e'({ecm_n, bmm_n, mcm_n});
            border_s0   <= !visible;
            if (mcm_prev_n && cell_mc) begin
                // Hold the pair on the second dot
                if (mc_cur) begin
                    pv_bits <= pixels_cur[7:6];
                end
            end else if (!mcm_prev_n && cell_mc) begin
                pv_bits <= {pixels_cur[7], 1'b0};
            end else begin
                pv_bits <= {2{pixels_cur[7]}};
            end
        end
    end

    always_comb begin
        case (pv_mode)
            MODE_STD_CHAR:
                color_dec = pv_bits[1] ? char_shift[11:8] : b0c_s;
            MODE_MC_CHAR: begin
                if (char_shift[11]) begin
                    case (pv_bits)
                        2'b00:   color_dec = b0c_s;
                        2'b01:   color_dec = b1c_s;
                        2'b10:   color_dec = b2c_s;
                        default: color_dec = {1'b0, char_shift[10:8]};
                    endcase
                end else begin
                    color_dec = pv_bits[1] ? {1'b0, char_shift[10:8]} : b0c_s;
                end
            end
            MODE_STD_BITMAP:
                color_dec = pv_bits[1] ? char_shift[7:4] : char_shift[3:0];
            MODE_MC_BITMAP: begin
                case (pv_bits)
                    2'b00:   color_dec = b0c_s;
                    2'b01:   color_dec = char_shift[7:4];
                    2'b10:   color_dec = char_shift[3:0];
                    default: color_dec = char_shift[11:8];
                endcase
            end
            MODE_ECM: begin
                // Background picked by the top two code bits
                case ({pv_bits[1], char_shift[7:6]})
                    3'b000:  color_dec = b0c_s;
                    3'b001:  color_dec = b1c_s;
                    3'b010:  color_dec = b2c_s;
                    3'b011:  color_dec = b3c_s;
                    default: color_dec = char_shift[11:8];
                endcase
            end
            default:
                color_dec = COLOR_BLACK;
        endcase

        if (border_s0) begin
            color_dec = ec_s;
        end
    end

    // Colour registers apply from the following dot
    always_ff @(posedge clk_dot4x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            b0c_s <= COLOR_BLACK;
            b1c_s <= COLOR_BLACK;
            b2c_s <= COLOR_BLACK;
            b3c_s <= COLOR_BLACK;
            ec_s  <= COLOR_BLACK;
        end else if (stage0) begin
            b0c_s <= b0c_i;
            b1c_s <= b1c_i;
            b2c_s <= b2c_i;
            b3c_s <= b3c_i;
            ec_s  <= ec_i;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (stage0) begin
            color_s1 <= color_dec;
        end
        if (stage1) begin
            pixel_color_o <= color_s1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/vic_pkg.sv
`default_nettype none

package vic_pkg;

    // Display modes, encoded as {ECM, BMM, MCM}
    typedef enum logic [2:0] {
        MODE_STD_CHAR       = 3'b000,
        MODE_MC_CHAR        = 3'b001,
        MODE_STD_BITMAP     = 3'b010,
        MODE_MC_BITMAP      = 3'b011,
        MODE_ECM            = 3'b100,
        MODE_INV_ECM_MC     = 3'b101,
        MODE_INV_ECM_BITMAP = 3'b110,
        MODE_INV_ECM_MC_BMP = 3'b111
    } mode_e;

    localparam logic [3:0] COLOR_BLACK = 4'h0;

    // Character cycles that carry display data
    localparam logic [6:0] VIS_FIRST = 7'd15;
    localparam logic [6:0] VIS_LAST  = 7'd54;

    // PAL timing, 63 cycles per raster line
    localparam int CYCLES_PER_LINE = 63;

    // Register map
    localparam logic [2:0] REG_B0C     = 3'd0;
    localparam logic [2:0] REG_B1C     = 3'd1;
    localparam logic [2:0] REG_B2C     = 3'd2;
    localparam logic [2:0] REG_B3C     = 3'd3;
    localparam logic [2:0] REG_EC      = 3'd4;
    // Control byte holds ECM in bit 2, BMM in bit 1 and MCM in bit 0
    localparam logic [2:0] REG_CTRL    = 3'd5;
    localparam logic [2:0] REG_XSCROLL = 3'd6;

endpackage

`default_nettype wire

//--- hdl/vic_regs.sv
`timescale 1ns/10ps
`default_nettype none

module vic_regs
    import vic_pkg::*;
(
    input  wire        clk_dot4x,
    input  wire        rst_n_i,
    input  wire        reg_we_i,
    input  wire  [2:0] reg_addr_i,
    input  wire  [7:0] reg_wdata_i,
    output logic [3:0] b0c_o,
    output logic [3:0] b1c_o,
    output logic [3:0] b2c_o,
    output logic [3:0] b3c_o,
    output logic [3:0] ec_o,
    output logic       ecm_o,
    output logic       bmm_o,
    output logic       mcm_o,
    output logic [2:0] xscroll_o
);

    always_ff @(posedge clk_dot4x or negedge rst_n_i) begin
        if (!rst_n_i) begin
            b0c_o     <= COLOR_BLACK;
            b1c_o     <= COLOR_BLACK;
            b2c_o     <= COLOR_BLACK;
            b3c_o     <= COLOR_BLACK;
            ec_o      <= COLOR_BLACK;
            ecm_o     <= 1'b0;
            bmm_o     <= 1'b0;
            mcm_o     <= 1'b0;
            xscroll_o <= 3'd0;
        end else if (reg_we_i) begin
            // Colours only keep the low nibble
            case (reg_addr_i)
                REG_B0C:     b0c_o <= reg_wdata_i[3:0];
                REG_B1C:     b1c_o <= reg_wdata_i[3:0];
                REG_B2C:     b2c_o <= reg_wdata_i[3:0];
                REG_B3C:     b3c_o <= reg_wdata_i[3:0];
                REG_EC:      ec_o  <= reg_wdata_i[3:0];
                REG_CTRL: begin
                    ecm_o <= reg_wdata_i[2];
                    bmm_o <= reg_wdata_i[1];
                    mcm_o <= reg_wdata_i[0];
                end
                REG_XSCROLL: xscroll_o <= reg_wdata_i[2:0];
                default: begin
                    // Address 7 is not mapped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/vic_video_top.sv
`timescale 1ns/10ps
`default_nettype none

module vic_video_top
    import vic_pkg::*;
#(
    parameter int cycles_per_line = CYCLES_PER_LINE
) (
    input  wire         clk_dot4x,
    input  wire         rst_n_i,
    input  wire         reg_we_i,
    input  wire  [2:0]  reg_addr_i,
    input  wire  [7:0]  reg_wdata_i,
    input  wire  [11:0] char_i,
    input  wire  [7:0]  pixels_i,
    output wire  [6:0]  cycle_num_o,
    output wire  [3:0]  pixel_color_o,
    output wire         pixel_valid_o
);

    wire [3:0] dot_rising;
    wire [2:0] cycle_bit;
    wire       phi_dav;
    wire [3:0] b0c;
    wire [3:0] b1c;
    wire [3:0] b2c;
    wire [3:0] b3c;
    wire [3:0] ec;
    wire       ecm;
    wire       bmm;
    wire       mcm;
    wire [2:0] xscroll;

    dot_timing #(
        .cycles_per_line (cycles_per_line)
    ) u_dot_timing (
        .clk_dot4x    (clk_dot4x),
        .rst_n_i      (rst_n_i),
        .dot_rising_o (dot_rising),
        .cycle_bit_o  (cycle_bit),
        .cycle_num_o  (cycle_num_o),
        .phi_dav_o    (phi_dav)
    );

    vic_regs u_vic_regs (
        .clk_dot4x   (clk_dot4x),
        .rst_n_i     (rst_n_i),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .b0c_o       (b0c),
        .b1c_o       (b1c),
        .b2c_o       (b2c),
        .b3c_o       (b3c),
        .ec_o        (ec),
        .ecm_o       (ecm),
        .bmm_o       (bmm),
        .mcm_o       (mcm),
        .xscroll_o   (xscroll)
    );

    pixel_sequencer u_pixel_sequencer (
        .clk_dot4x     (clk_dot4x),
        .rst_n_i       (rst_n_i),
        .dot_rising_i  (dot_rising),
        .cycle_bit_i   (cycle_bit),
        .cycle_num_i   (cycle_num_o),
        .phi_dav_i     (phi_dav),
        .char_i        (char_i),
        .pixels_i      (pixels_i),
        .b0c_i         (b0c),
        .b1c_i         (b1c),
        .b2c_i         (b2c),
        .b3c_i         (b3c),
        .ec_i          (ec),
        .ecm_i         (ecm),
        .bmm_i         (bmm),
        .mcm_i         (mcm),
        .xscroll_i     (xscroll),
        .pixel_color_o (pixel_color_o),
        .pixel_valid_o (pixel_valid_o)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the video path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_vic_video \
    -f files.f \
    -o Vtb_vic_video

./obj_dir/Vtb_vic_video > sim.log 2>&1 || true
cat sim.log

if grep -q "sim passed" sim.log; then
    exit 0
fi
exit 1

//--- verif/pixel_checker.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_checker
    import vic_pkg::*;
(
    input  wire         clk_dot4x,
    input  wire         rst_n_i,
    input  wire         reg_we_i,
    input  wire  [2:0]  reg_addr_i,
    input  wire  [7:0]  reg_wdata_i,
    input  wire  [11:0] char_i,
    input  wire  [7:0]  pixels_i,
    input  wire  [6:0]  cycle_num_i,
    input  wire  [3:0]  pixel_color_i,
    input  wire         pixel_valid_i,
    input  wire         check_en_i,
    input  wire  [7:0]  test_num_i,
    output int          dot_errors_o,
    output int          failed_tests_o
);

    logic [3:0]  b0c;
    logic [3:0]  b1c;
    logic [3:0]  b2c;
    logic [3:0]  b3c;
    logic [3:0]  ec;
    logic [2:0]  mode;
    logic [2:0]  xscroll;
    // One entry per clock of {ec, b3c, b2c, b1c, b0c} as the DUT sees it
    logic [19:0] col_hist [0:5];
    logic [6:0]  last_cyc;
    logic [2:0]  next_bit;
    logic        check_en_d;
    int          test_dots;
    int          test_errs;

    // Colour of the dot at position j inside the cell
    function automatic logic [3:0] decode_dot(input logic [2:0] m, input logic [15:0] bgs,
                                              input logic [11:0] ch, input logic [7:0] pix,
                                              input logic [2:0] j);
        logic       fg;
        logic [2:0] hi;
        logic [1:0] pair;
        logic [3:0] bg;
        fg   = pix[3'd7 - j];
        hi   = 3'd7 - {j[2:1], 1'b0};
        pair = {pix[hi], pix[hi - 3'd1]};
        case (ch[7:6])
            2'd0:    bg = bgs[3:0];
            2'd1:    bg = bgs[7:4];
            2'd2:    bg = bgs[11:8];
            default: bg = bgs[15:12];
        endcase
        case (m)
            3'b000: return fg ? ch[11:8] : bgs[3:0];
            3'b001: begin
                if (!ch[11]) begin
                    return fg ? {1'b0, ch[10:8]} : bgs[3:0];
                end
                case (pair)
                    2'b00:   return bgs[3:0];
                    2'b01:   return bgs[7:4];
                    2'b10:   return bgs[11:8];
                    default: return {1'b0, ch[10:8]};
                endcase
            end
            3'b010: return fg ? ch[7:4] : ch[3:0];
            3'b011: begin
                case (pair)
                    2'b00:   return bgs[3:0];
                    2'b01:   return ch[7:4];
                    2'b10:   return ch[3:0];
                    default: return ch[11:8];
                endcase
            end
            3'b100: return fg ? ch[11:8] : bg;
            default: return COLOR_BLACK;
        endcase
    endfunction

    always @(posedge clk_dot4x or negedge rst_n_i) begin : watch
        logic [6:0]  cyc;
        logic [6:0]  exp_cyc;
        logic [2:0]  bit_idx;
        logic [2:0]  j;
        logic [19:0] cols;
        logic [11:0] ch;
        logic [7:0]  pix;
        logic [3:0]  exp_col;
        int          errs;
        if (!rst_n_i) begin
            {b0c, b1c, b2c, b3c, ec} <= '0;
            mode           <= 3'd0;
            xscroll        <= 3'd0;
            last_cyc       <= 7'd0;
            next_bit       <= 3'd0;
            check_en_d     <= 1'b0;
            test_dots      <= 0;
            test_errs      <= 0;
            dot_errors_o   <= 0;
            failed_tests_o <= 0;
            for (int i = 0; i < 6; i++) begin
                col_hist[i] <= '0;
            end
        end else begin
            col_hist[0] <= {ec, b3c, b2c, b1c, b0c};
            for (int i = 1; i < 6; i++) begin
                col_hist[i] <= col_hist[i-1];
            end
            if (reg_we_i) begin
                case (reg_addr_i)
                    REG_B0C:     b0c     <= reg_wdata_i[3:0];
                    REG_B1C:     b1c     <= reg_wdata_i[3:0];
                    REG_B2C:     b2c     <= reg_wdata_i[3:0];
                    REG_B3C:     b3c     <= reg_wdata_i[3:0];
                    REG_EC:      ec      <= reg_wdata_i[3:0];
                    REG_CTRL:    mode    <= reg_wdata_i[2:0];
                    REG_XSCROLL: xscroll <= reg_wdata_i[2:0];
                    default: begin
                    end
                endcase
            end

            if (pixel_valid_i) begin
                errs = 0;
                // The pulse of dot 7 arrives after the cycle counter has moved on
                if (cycle_num_i != last_cyc) begin
                    cyc      = last_cyc;
                    bit_idx  = 3'd7;
                    next_bit <= 3'd0;
                    last_cyc <= cycle_num_i;
                    // Eight dots per cycle and the counter wraps at the line length
                    exp_cyc  = (last_cyc == 7'(CYCLES_PER_LINE - 1)) ? 7'd0 : last_cyc + 7'd1;
                    if (check_en_i && next_bit != 3'd7) begin
                        $display("[FAIL] %0t ns: test %0d cycle %0d has %0d dots, expected 8",
                                 $time, test_num_i, last_cyc, int'(next_bit) + 1);
                        errs = errs + 1;
                    end
                    if (check_en_i && cycle_num_i !== exp_cyc) begin
                        $display("[FAIL] %0t ns: test %0d cycle %0d followed by %0d, expected %0d",
                                 $time, test_num_i, last_cyc, cycle_num_i, exp_cyc);
                        errs = errs + 1;
                    end
                end else begin
                    cyc      = cycle_num_i;
                    bit_idx  = next_bit;
                    next_bit <= next_bit + 3'd1;
                end
                cols = col_hist[5];
                ch   = char_i;
                pix  = pixels_i;
                j    = bit_idx - xscroll;
                // Dots ahead of the scroll point in the first cycle show an empty cell
                if (bit_idx < xscroll && cyc == VIS_FIRST) begin
                    ch  = 12'd0;
                    pix = 8'd0;
                end
                if (cyc < VIS_FIRST || cyc > VIS_LAST) begin
                    exp_col = cols[19:16];
                end else begin
                    exp_col = decode_dot(mode, cols[15:0], ch, pix, j);
                end
                if (check_en_i) begin
                    test_dots <= test_dots + 1;
                    if (pixel_color_i !== exp_col) begin
                        $display("[FAIL] %0t ns: test %0d cycle %0d dot %0d expected %h got %h",
                                 $time, test_num_i, cyc, bit_idx, exp_col, pixel_color_i);
                        errs = errs + 1;
                    end
                end
                test_errs    <= test_errs + errs;
                dot_errors_o <= dot_errors_o + errs;
            end

            check_en_d <= check_en_i;
            if (check_en_d && !check_en_i) begin
                if (test_dots == 0) begin
                    $display("test %0d saw no output dots", test_num_i);
                    failed_tests_o <= failed_tests_o + 1;
                end else if (test_errs != 0) begin
                    $display("test %0d: %0d dots, %0d wrong", test_num_i, test_dots, test_errs);
                    failed_tests_o <= failed_tests_o + 1;
                end else begin
                    $display("test %0d: %0d dots, all correct", test_num_i, test_dots);
                end
                test_dots <= 0;
                test_errs <= 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_vic_video.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vic_video
    import vic_pkg::*;
;

    localparam int     NUM_ROWS    = 14;
    localparam int     CLK_PERIOD  = 40;
    localparam longint LINE_CLOCKS = CYCLES_PER_LINE * 32;
    // Each row takes at most two lines, plus reset and the tail
    localparam longint WATCHDOG_NS = (NUM_ROWS * 2 + 4) * LINE_CLOCKS * CLK_PERIOD;

    typedef struct packed {
        logic [2:0]  mode;
        logic [15:0] bgs;
        logic [3:0]  ec;
        logic [2:0]  xscroll;
        logic [11:0] chr;
        logic [7:0]  pix;
        logic        rnd;
        logic        ec_change;
        logic [3:0]  ec_mid;
    } row_t;

    row_t        rows [NUM_ROWS];
    logic        clk_dot4x;
    logic        rst_n;
    logic        reg_we;
    logic [2:0]  reg_addr;
    logic [7:0]  reg_wdata;
    logic [11:0] char_in;
    logic [7:0]  pixels_in;
    wire  [6:0]  cycle_num_o;
    wire  [3:0]  pixel_color_o;
    wire         pixel_valid_o;
    logic        check_en;
    logic [7:0]  test_num;
    int          dot_errors;
    int          failed_tests;
    logic [31:0] lfsr_state;

    initial clk_dot4x = 1'b0;
    always #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;

    vic_video_top u_dut (
        .clk_dot4x     (clk_dot4x),
        .rst_n_i       (rst_n),
        .reg_we_i      (reg_we),
        .reg_addr_i    (reg_addr),
        .reg_wdata_i   (reg_wdata),
        .char_i        (char_in),
        .pixels_i      (pixels_in),
        .cycle_num_o   (cycle_num_o),
        .pixel_color_o (pixel_color_o),
        .pixel_valid_o (pixel_valid_o)
    );

    pixel_checker u_checker (
        .clk_dot4x      (clk_dot4x),
        .rst_n_i        (rst_n),
        .reg_we_i       (reg_we),
        .reg_addr_i     (reg_addr),
        .reg_wdata_i    (reg_wdata),
        .char_i         (char_in),
        .pixels_i       (pixels_in),
        .cycle_num_i    (cycle_num_o),
        .pixel_color_i  (pixel_color_o),
        .pixel_valid_i  (pixel_valid_o),
        .check_en_i     (check_en),
        .test_num_i     (test_num),
        .dot_errors_o   (dot_errors),
        .failed_tests_o (failed_tests)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        b = 8'd0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic row_t build_row(input logic [2:0] mode, input logic [15:0] bgs,
                                       input logic [3:0] ec, input logic [2:0] xscroll,
                                       input logic [11:0] chr, input logic [7:0] pix,
                                       input logic rnd, input logic ec_change,
                                       input logic [3:0] ec_mid);
        row_t r;
        r = {mode, bgs, ec, xscroll, chr, pix, rnd, ec_change, ec_mid};
        return r;
    endfunction

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] data);
        reg_we    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk_dot4x);
        reg_we    = 1'b0;
    endtask

    task automatic wait_cycle(input logic [6:0] n);
        @(negedge clk_dot4x);
        while (cycle_num_o != n) begin
            @(negedge clk_dot4x);
        end
    endtask

    initial begin
        logic [7:0] rnd_pix;
        reg_we     = 1'b0;
        reg_addr   = 3'd0;
        reg_wdata  = 8'd0;
        char_in    = 12'd0;
        pixels_in  = 8'd0;
        check_en   = 1'b0;
        test_num   = 8'd0;
        lfsr_state = 32'hc7da;
        rst_n      = 1'b0;

        // Mode, colours {b3c, b2c, b1c, b0c}, ec, xscroll, char, pixels
        rows[0]  = build_row(3'b000, 16'h8526, 4'he, 3'd0, 12'h700, 8'h00, 1, 0, 4'h0);
        rows[1]  = build_row(3'b010, 16'h8526, 4'he, 3'd0, 12'h0a5, 8'h00, 1, 0, 4'h0);
        rows[2]  = build_row(3'b001, 16'h8526, 4'hd, 3'd0, 12'hb00, 8'h00, 1, 0, 4'h0);
        rows[3]  = build_row(3'b001, 16'h8526, 4'hd, 3'd0, 12'h600, 8'h00, 1, 0, 4'h0);
        rows[4]  = build_row(3'b011, 16'h8526, 4'hc, 3'd0, 12'h9c3, 8'h00, 1, 0, 4'h0);
        rows[5]  = build_row(3'b100, 16'h8526, 4'hc, 3'd0, 12'hec0, 8'h00, 1, 0, 4'h0);
        rows[6]  = build_row(3'b100, 16'h4b1f, 4'ha, 3'd0, 12'h340, 8'h00, 1, 0, 4'h0);
        rows[7]  = build_row(3'b101, 16'h4b1f, 4'ha, 3'd0, 12'hbff, 8'h00, 1, 0, 4'h0);
        rows[8]  = build_row(3'b110, 16'h4b1f, 4'h9, 3'd0, 12'h7a5, 8'h00, 1, 0, 4'h0);
        rows[9]  = build_row(3'b111, 16'h4b1f, 4'h9, 3'd0, 12'hfc3, 8'h00, 1, 0, 4'h0);
        // Single lit dot shows where the scroll puts the cell start
        rows[10] = build_row(3'b000, 16'h0006, 4'he, 3'd0, 12'h100, 8'h80, 0, 0, 4'h0);
        rows[11] = build_row(3'b000, 16'h0006, 4'he, 3'd3, 12'h100, 8'h80, 0, 0, 4'h0);
        rows[12] = build_row(3'b000, 16'h0006, 4'he, 3'd7, 12'h100, 8'h80, 0, 0, 4'h0);
        rows[13] = build_row(3'b000, 16'h0006, 4'he, 3'd0, 12'h200, 8'h00, 1, 1, 4'h3);

        repeat (10) @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].rnd) begin
                random_byte(rnd_pix);
                rows[r].pix = rnd_pix;
            end
            // Registers and data change only in the right border
            wait_cycle(7'd57);
            write_reg(REG_B0C, {4'h0, rows[r].bgs[3:0]});
            write_reg(REG_B1C, {4'h0, rows[r].bgs[7:4]});
            write_reg(REG_B2C, {4'h0, rows[r].bgs[11:8]});
            write_reg(REG_B3C, {4'h0, rows[r].bgs[15:12]});
            write_reg(REG_EC, {4'h0, rows[r].ec});
            write_reg(REG_CTRL, {5'd0, rows[r].mode});
            write_reg(REG_XSCROLL, {5'd0, rows[r].xscroll});
            char_in   = rows[r].chr;
            pixels_in = rows[r].pix;
            test_num  = 8'(r);
            wait_cycle(7'd0);
            check_en = 1'b1;
            if (rows[r].ec_change) begin
                wait_cycle(7'd5);
                write_reg(REG_EC, {4'h0, rows[r].ec_mid});
            end
            wait_cycle(7'd57);
            check_en = 1'b0;
        end

        repeat (8) @(negedge clk_dot4x);
        $display("tests %0d, failed tests %0d, wrong dots %0d", NUM_ROWS, failed_tests,
                 dot_errors);
        if (failed_tests == 0 && dot_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not reach its end in the expected time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
